/* mmio_subsystem.f */
+incdir+include
src/mmio_pkg.sv
src/io_bus_if.sv
src/mmio_decoder.sv
src/spi_port_regs.sv
src/spi_master.sv
src/led_port_regs.sv
src/gpio_port_regs.sv
src/mmio_subsystem.sv
verif/tb_mmio_subsystem.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_mmio_subsystem
FILELIST  = mmio_subsystem.f
LOG       = sim.log
FAIL_MSG  = TEST RESULT: FAIL
PASS_MSG  = TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no result line found in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* verif/mmio_patterns.txt */
# op addr data expected. R reads addr with mem_rd=data, W writes data then reads back,
# S runs an SPI loopback of the low data byte, G drives gpio_in=data then reads addr.
R 00001000 12345678 12345678
R 7ffffffc a5a5a5a5 a5a5a5a5
R 80000100 0badf00d 0badf00d
R fffffff0 13572468 13572468
W 80000040 1234abcd 0000abcd
R 80000044 00000000 ffffffff
R 8000007c 00000000 ffffffff
W 80000084 000000c3 000000c3
G 80000080 0000005a 0000005a
G 80000080 000000a5 000000a5
W 800000c0 deadbeef ffffffff
W 80000048 55555555 ffffffff
S 80000000 0000003c 0000003c
S 80000000 000000a7 000000a7
R 80000008 00000000 ffffffff
R 800000fc 00000000 ffffffff

/* verif/tb_mmio_subsystem.sv */
`include "mmio_config.svh"

module tb_mmio_subsystem;
    timeunit 1ns;
    timeprecision 100ps;
    import mmio_pkg::*;

    localparam word_t LED_ADDR      = 32'h8000_0040;    // LED register.
    localparam word_t GPIO_OUT_ADDR = 32'h8000_0084;    // GPIO output register.
    localparam int    POLL_LIMIT    = 64 * `SPI_CLK_DIV; // a transfer takes 16 half periods.

    logic                   clk;
    logic                   arst_n;
    word_t                  m_addr;
    logic                   m_we;
    word_t                  m_wd;
    word_t                  m_rd;
    word_t                  mem_addr;
    logic                   mem_we;
    word_t                  mem_wd;
    word_t                  mem_rd;
    led_t                   leds;
    logic [`GPIO_WIDTH-1:0] gpio_in;
    logic [`GPIO_WIDTH-1:0] gpio_out;
    logic                   sclk;
    logic                   mosi;
    logic                   miso;
    logic                   cs_n;

    int                     checks       = 0;  // compares done.
    int                     value_errors = 0;  // compares that failed.
    int                     other_errors = 0;  // timeouts and file problems.
    word_t                  lcg_state    = 32'h716b_1166;
    led_t                   led_model    = '0;  // what leds must show.
    logic [`GPIO_WIDTH-1:0] gpio_model   = '0;  // what gpio_out must show.

    assign miso = mosi;  // loopback, so every byte comes back unchanged.

    mmio_subsystem u_mmio_subsystem (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period.
    end

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_leds(input led_t got, input led_t exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: leds are %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_mem(input word_t got_addr, input logic got_we, input word_t got_wd,
                             input word_t exp_addr, input logic exp_we, input word_t exp_wd);
        checks++;
        if (got_addr !== exp_addr || got_we !== exp_we || got_wd !== exp_wd) begin
            value_errors++;
            $display("[ERROR] %0t: mem port addr %h we %b wd %h, expected %h %b %h",
                     $time, got_addr, got_we, got_wd, exp_addr, exp_we, exp_wd);
        end
    endtask

    task automatic check_spi_pins(input logic got_sclk, input logic got_cs_n,
                                  input logic exp_sclk, input logic exp_cs_n);
        checks++;
        if (got_sclk !== exp_sclk || got_cs_n !== exp_cs_n) begin
            value_errors++;
            $display("[ERROR] %0t: SPI pins sclk %b cs_n %b, expected sclk %b cs_n %b",
                     $time, got_sclk, got_cs_n, exp_sclk, exp_cs_n);
        end
    endtask

    // one bus cycle; the I/O window is 0x8000_0000 to 0x8000_00FF.
    task automatic bus_access(input word_t addr, input logic we, input word_t wd,
                              input word_t mrd, output word_t rd);
        logic is_io;
        is_io = (addr >= 32'h8000_0000) && (addr <= 32'h8000_00FF);
        @(posedge clk);
        #5;
        m_addr = addr;
        m_we   = we;
        m_wd   = wd;
        mem_rd = mrd;
        @(negedge clk);  // combinational outputs have settled by now.
        rd = m_rd;
        check_mem(mem_addr, mem_we, mem_wd, is_io ? 32'h0 : addr, we && !is_io, wd);
    endtask

    task automatic bus_idle();
        @(posedge clk);  // a pending write commits here.
        #5;
        m_we   = 1'b0;
        m_addr = '0;
    endtask

    task automatic write_check(input word_t addr, input word_t data, input word_t exp);
        word_t rd;
        bus_access(addr, 1'b1, data, '0, rd);
        if (addr == LED_ADDR) led_model = data[15:0];
        if (addr == GPIO_OUT_ADDR) gpio_model = data[`GPIO_WIDTH-1:0];
        bus_idle();
        @(negedge clk);  // outputs change one edge after the write.
        check_leds(leds, led_model);
        check_word(word_t'(gpio_out), word_t'(gpio_model), "gpio_out");
        bus_access(addr, 1'b0, '0, '0, rd);
        check_word(rd, exp, $sformatf("read-back of %h", addr));
    endtask

    task automatic gpio_check(input word_t addr, input word_t data, input word_t exp);
        word_t rd;
        @(posedge clk);
        #5;
        gpio_in = data[`GPIO_WIDTH-1:0];
        repeat (2) @(posedge clk);  // two synchronizer stages.
        bus_access(addr, 1'b0, '0, '0, rd);
        check_word(rd, exp, "synchronized gpio_in");
    endtask

    task automatic spi_loopback(input word_t addr, input word_t data, input word_t exp);
        word_t rd;
        int    polls;
        bus_access(addr, 1'b1, data, '0, rd);           // transmit byte.
        bus_access(addr + 32'd4, 1'b1, 32'h4, '0, rd);  // start bit.
        polls = 0;
        do begin
            bus_access(addr + 32'd4, 1'b0, '0, '0, rd);
            polls++;
        end while (!rd[1] && polls < POLL_LIMIT);
        if (!rd[1]) begin
            other_errors++;
            $display("timeout at %0t: SPI busy never went high after start", $time);
        end else begin
            check_word(rd, 32'h2, "SPI status during transfer");  // rdy cleared by start.
            check_spi_pins(sclk, cs_n, 1'b0, 1'b0);  // selected, first sclk edge not yet due.
        end
        bus_access(addr, 1'b1, ~data, '0, rd);          // must not replace the byte.
        bus_access(addr + 32'd4, 1'b1, 32'h4, '0, rd);  // this start is dropped.
        polls = 0;
        do begin
            bus_access(addr + 32'd4, 1'b0, '0, '0, rd);
            polls++;
        end while (rd[1] && polls < POLL_LIMIT);
        if (rd[1]) begin
            other_errors++;
            $display("timeout at %0t: SPI busy never went low after the transfer", $time);
        end
        check_word(rd, 32'h1, "SPI status after transfer");  // rdy set, busy clear.
        check_spi_pins(sclk, cs_n, 1'b0, 1'b1);               // deselected with sclk idle.
        bus_access(addr, 1'b0, '0, '0, rd);
        check_word(rd, exp, "SPI receive byte");
    endtask

    task automatic run_random_memory(input int count);
        word_t addr;
        word_t wd;
        word_t mrd;
        word_t r;
        word_t rd;
        for (int i = 0; i < count; i++) begin
            addr = lcg_next();
            addr = (i % 2 == 0) ? (addr & 32'h7FFF_FFFF) : (addr | 32'h8000_0100);
            wd   = lcg_next();
            mrd  = lcg_next();
            r    = lcg_next();
            bus_access(addr, r[0], wd, mrd, rd);
            check_word(rd, mrd, $sformatf("memory read of %h", addr));
        end
        bus_idle();
    endtask

    task automatic run_patterns();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        word_t       addr;
        word_t       data;
        word_t       exp;
        word_t       rd;
        fd = $fopen("verif/mmio_patterns.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the pattern file verif/mmio_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %h %h %h", op, addr, data, exp);
                    if (n == 4) begin
                        case (op)
                            "R": begin
                                bus_access(addr, 1'b0, '0, data, rd);
                                check_word(rd, exp, $sformatf("read of %h", addr));
                            end
                            "W": write_check(addr, data, exp);
                            "G": gpio_check(addr, data, exp);
                            "S": spi_loopback(addr, data, exp);
                            default: begin
                                other_errors++;
                                $display("unknown operation in pattern line: %s", line);
                            end
                        endcase
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        arst_n  = 1'b0;
        m_addr  = '0;
        m_we    = 1'b0;
        m_wd    = '0;
        mem_rd  = '0;
        gpio_in = '0;
        repeat (8) @(posedge clk);
        #5;
        arst_n = 1'b1;
        @(negedge clk);
        check_leds(leds, '0);                                 // LEDs dark after reset.
        check_word(word_t'(gpio_out), '0, "gpio_out after reset");
        check_spi_pins(sclk, cs_n, 1'b0, 1'b1);               // SPI idle after reset.
        run_random_memory(16);
        run_patterns();
        bus_idle();
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* src/mmio_subsystem.sv */
`include "mmio_config.svh"

module mmio_subsystem (
    input  logic                   clk,       // system clock.
    input  logic                   arst_n,    // asynchronous reset, active low.
    input  mmio_pkg::word_t        m_addr,    // processor data bus address.
    input  logic                   m_we,      // processor write enable.
    input  mmio_pkg::word_t        m_wd,      // processor write data.
    output mmio_pkg::word_t        m_rd,      // read data to the processor.
    output mmio_pkg::word_t        mem_addr,  // address to data memory.
    output logic                   mem_we,    // write enable to data memory.
    output mmio_pkg::word_t        mem_wd,    // write data to data memory.
    input  mmio_pkg::word_t        mem_rd,    // read data from data memory.
    output mmio_pkg::led_t         leds,      // LED bank.
    input  logic [`GPIO_WIDTH-1:0] gpio_in,   // GPIO input pins.
    output logic [`GPIO_WIDTH-1:0] gpio_out,  // GPIO output pins.
    output logic                   sclk,      // SPI clock.
    output logic                   mosi,      // SPI data out.
    input  logic                   miso,      // SPI data in.
    output logic                   cs_n       // SPI chip select.
);
    logic       spi_start;    // start pulse from the SPI registers.
    logic [7:0] spi_tx_byte;  // byte to send.
    logic       spi_busy;     // transfer in progress.
    logic       spi_rdy;      // transfer done.
    logic [7:0] spi_rx_byte;  // byte received.

    io_bus_if spi_bus ();   // slot 0.
    io_bus_if led_bus ();   // slot 1.
    io_bus_if gpio_bus ();  // slot 2.

    mmio_decoder u_mmio_decoder (
        .m_addr   (m_addr),
        .m_we     (m_we),
        .m_wd     (m_wd),
        .m_rd     (m_rd),
        .mem_addr (mem_addr),
        .mem_we   (mem_we),
        .mem_wd   (mem_wd),
        .mem_rd   (mem_rd),
        .slot0    (spi_bus.master),
        .slot1    (led_bus.master),
        .slot2    (gpio_bus.master)
    );

    spi_port_regs u_spi_port_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .bus     (spi_bus.slave),
        .start   (spi_start),
        .tx_byte (spi_tx_byte),
        .busy    (spi_busy),
        .rdy     (spi_rdy),
        .rx_byte (spi_rx_byte)
    );

    spi_master u_spi_master (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (spi_start),
        .tx_byte (spi_tx_byte),
        .busy    (spi_busy),
        .rdy     (spi_rdy),
        .rx_byte (spi_rx_byte),
        .sclk    (sclk),
        .mosi    (mosi),
        .miso    (miso),
        .cs_n    (cs_n)
    );

    led_port_regs u_led_port_regs (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (led_bus.slave),
        .leds   (leds)
    );

    gpio_port_regs u_gpio_port_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .bus      (gpio_bus.slave),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

endmodule

/* src/gpio_port_regs.sv */
`include "mmio_config.svh"

module gpio_port_regs (
    input  logic                   clk,       // system clock.
    input  logic                   arst_n,    // asynchronous reset, active low.
    io_bus_if.slave                bus,       // access from the decoder, slot 2.
    input  logic [`GPIO_WIDTH-1:0] gpio_in,   // pins from outside, not aligned to clk.
    output logic [`GPIO_WIDTH-1:0] gpio_out   // pins driven from the output register.
);
    import mmio_pkg::*;

    localparam reg_off_t OFF_IN  = reg_off_t'(0);  // offset 0x00, synchronized inputs.
    localparam reg_off_t OFF_OUT = reg_off_t'(1);  // offset 0x04, output register.

    logic [`GPIO_WIDTH-1:0] sync_q1;  // first flop, may go metastable.
    logic [`GPIO_WIDTH-1:0] sync_q2;  // second flop, safe to read.
    logic                   wr_out;   // write to the output register in this cycle.

    assign wr_out = bus.en && bus.we && (bus.off == OFF_OUT);

    // an input change reaches the read path two clocks later.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= gpio_in;
            sync_q2 <= sync_q1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gpio_out <= '0;                             // outputs low after reset.
        end else if (wr_out) begin
            gpio_out <= bus.wd[`GPIO_WIDTH-1:0];        // pins change one cycle later.
        end
    end

    always_comb begin
        case (bus.off)
            OFF_IN:  bus.rd = word_t'(sync_q2);    // zero above the pin bits.
            OFF_OUT: bus.rd = word_t'(gpio_out);   // read-back of the output register.
            default: bus.rd = `IO_UNMAPPED_RD;
        endcase
    end

endmodule

/* src/led_port_regs.sv */
`include "mmio_config.svh"

module led_port_regs (
    input  logic            clk,     // system clock.
    input  logic            arst_n,  // asynchronous reset, active low.
    io_bus_if.slave         bus,     // access from the decoder, slot 1.
    output mmio_pkg::led_t  leds     // LED bank, driven straight from the register.
);
    import mmio_pkg::*;

    localparam reg_off_t OFF_LED = reg_off_t'(0);  // offset 0x00 is the only register.

    logic wr_led;  // write to the LED register in this cycle.

    assign wr_led = bus.en && bus.we && (bus.off == OFF_LED);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            leds <= '0;                       // all LEDs dark after reset.
        end else if (wr_led) begin
            leds <= bus.wd[15:0];             // upper half of the word is dropped.
        end
    end

    always_comb begin
        if (bus.off == OFF_LED) begin
            bus.rd = {16'b0, leds};           // read-back mirrors the register.
        end else begin
            bus.rd = `IO_UNMAPPED_RD;
        end
    end

endmodule

/* src/spi_master.sv */
`include "mmio_config.svh"

module spi_master (
    input  logic       clk,      // system clock.
    input  logic       arst_n,   // asynchronous reset, active low.
    input  logic       start,    // one-cycle request for a transfer.
    input  logic [7:0] tx_byte,  // byte to send, most significant bit first.
    output logic       busy,     // high for the whole transfer.
    output logic       rdy,      // set when a transfer completes, cleared by start.
    output logic [7:0] rx_byte,  // byte received in the last transfer.
    output logic       sclk,     // SPI clock, idle low in mode 0.
    output logic       mosi,     // serial data to the device.
    input  logic       miso,     // serial data from the device.
    output logic       cs_n      // chip select, active low.
);
    localparam int               DIV_W    = (`SPI_CLK_DIV > 1) ? $clog2(`SPI_CLK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SPI_CLK_DIV - 1);  // last count of a half.

    logic [DIV_W-1:0] div_cnt;   // clocks spent in the current sclk half period.
    logic [3:0]       edge_cnt;  // sclk edges so far, sixteen per byte.
    logic [7:0]       tx_shift;  // outgoing bits, the next one at the top.
    logic [7:0]       rx_shift;  // incoming bits, the newest one at the bottom.
    logic             tick;      // sclk toggles at this edge.
    logic             accept;    // a start request that is taken.

    assign tick   = busy && (div_cnt == DIV_LAST);
    assign accept = start && !busy;            // a start during a transfer is ignored.
    assign mosi   = !cs_n && tx_shift[7];      // held low while deselected.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            rdy      <= 1'b0;
            cs_n     <= 1'b1;
            sclk     <= 1'b0;
            div_cnt  <= '0;
            edge_cnt <= '0;
        end else if (accept) begin
            busy     <= 1'b1;
            rdy      <= 1'b0;                  // the old result is no longer current.
            cs_n     <= 1'b0;                  // select falls one cycle after start.
            div_cnt  <= '0;
            edge_cnt <= '0;
        end else if (busy) begin
            div_cnt <= tick ? '0 : div_cnt + DIV_W'(1);
            if (tick) begin
                sclk     <= !sclk;
                edge_cnt <= edge_cnt + 4'd1;
                if (edge_cnt == 4'd15) begin   // the last falling edge ends the byte.
                    busy <= 1'b0;
                    cs_n <= 1'b1;
                    rdy  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tx_shift <= tx_byte;                        // bit 7 is on mosi before sclk rises.
        end else if (tick && !sclk) begin
            rx_shift <= {rx_shift[6:0], miso};          // rising edge samples the input.
        end else if (tick && sclk) begin
            tx_shift <= {tx_shift[6:0], 1'b0};          // falling edge moves to the next bit.
        end
    end

    always_ff @(posedge clk) begin
        if (tick && (edge_cnt == 4'd15)) begin
            rx_byte <= rx_shift;  // all eight bits are in after the last rising edge.
        end
    end

    sclk_idle_low: assert property (@(posedge clk) disable iff (!arst_n) cs_n |-> !sclk)
        else $error("sclk is high while the device is deselected.");

endmodule

/* src/spi_port_regs.sv */
`include "mmio_config.svh"

module spi_port_regs (
    input  logic       clk,      // system clock.
    input  logic       arst_n,   // asynchronous reset, active low.
    io_bus_if.slave    bus,      // access from the decoder, slot 0.
    output logic       start,    // one-cycle pulse that begins a transfer.
    output logic [7:0] tx_byte,  // byte to send, held while busy.
    input  logic       busy,     // a transfer is running.
    input  logic       rdy,      // the last transfer has finished.
    input  logic [7:0] rx_byte   // byte received by the last transfer.
);
    import mmio_pkg::*;

    localparam reg_off_t OFF_DATA  = reg_off_t'(0);  // offset 0x00, data register.
    localparam reg_off_t OFF_CTRL  = reg_off_t'(1);  // offset 0x04, control and status.
    localparam int       START_BIT = 2;              // control bit that starts a transfer.

    logic wr_data;  // write to the data register in this cycle.
    logic wr_ctrl;  // write to the control register in this cycle.

    assign wr_data = bus.en && bus.we && (bus.off == OFF_DATA);
    assign wr_ctrl = bus.en && bus.we && (bus.off == OFF_CTRL);

    // the shifter copies tx_byte at start, so it is frozen only while busy.
    always_ff @(posedge clk) begin
        if (wr_data && !busy) begin
            tx_byte <= bus.wd[7:0];  // only the low byte is sent.
        end
    end

    // a start request while busy is dropped here and again in the shifter.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start <= 1'b0;
        end else begin
            start <= wr_ctrl && bus.wd[START_BIT] && !busy;  // high for one cycle.
        end
    end

    always_comb begin
        case (bus.off)
            OFF_DATA: bus.rd = {24'b0, rx_byte};     // received byte in bits 7..0.
            OFF_CTRL: bus.rd = {30'b0, busy, rdy};   // software polls bit 1.
            default:  bus.rd = `IO_UNMAPPED_RD;      // no register at this offset.
        endcase
    end

endmodule

/* src/mmio_decoder.sv */
`include "mmio_config.svh"

module mmio_decoder (
    input  mmio_pkg::word_t m_addr,    // address of the current bus access.
    input  logic            m_we,      // the current access is a write.
    input  mmio_pkg::word_t m_wd,      // write data of the current access.
    output mmio_pkg::word_t m_rd,      // read data back to the processor.
    output mmio_pkg::word_t mem_addr,  // memory address, zero during I/O.
    output logic            mem_we,    // memory write enable, low during I/O.
    output mmio_pkg::word_t mem_wd,    // memory write data.
    input  mmio_pkg::word_t mem_rd,    // memory read data.
    io_bus_if.master        slot0,     // SPI controller.
    io_bus_if.master        slot1,     // LED register.
    io_bus_if.master        slot2      // GPIO block.
);
    import mmio_pkg::*;

    localparam word_t IO_BASE = `MMIO_IO_BASE;  // start of the I/O window.

    bus_addr_u                   addr_u;   // m_addr seen through both views.
    logic                        is_io;    // the access falls in the I/O window.
    logic [`MMIO_SLOT_COUNT-1:0] slot_en;  // one-hot enable of the addressed slot.

    assign addr_u = m_addr;  // the memory view is the raw word.

    // high bit set and the zero field clear, which is exactly the base prefix.
    assign is_io = {addr_u.io.is_io_high, addr_u.io.zero_field} == IO_BASE[31 -: ZERO_W + 1];

    assign slot_en = is_io ? (`MMIO_SLOT_COUNT'(1) << addr_u.io.slot) : '0;  // none for memory.

    assign mem_addr = is_io ? '0 : addr_u.mem;  // memory never sees an I/O address.
    assign mem_we   = m_we && !is_io;           // an I/O write must not reach memory.
    assign mem_wd   = m_wd;                     // data is harmless while mem_we is low.

    assign slot0.en  = slot_en[0];
    assign slot0.we  = m_we;
    assign slot0.off = addr_u.io.offset;
    assign slot0.wd  = m_wd;

    assign slot1.en  = slot_en[1];
    assign slot1.we  = m_we;
    assign slot1.off = addr_u.io.offset;
    assign slot1.wd  = m_wd;

    assign slot2.en  = slot_en[2];
    assign slot2.we  = m_we;
    assign slot2.off = addr_u.io.offset;
    assign slot2.wd  = m_wd;

    always_comb begin
        if (slot_en[0]) begin
            m_rd = slot0.rd;
        end else if (slot_en[1]) begin
            m_rd = slot1.rd;
        end else if (slot_en[2]) begin
            m_rd = slot2.rd;
        end else if (slot_en[3]) begin
            m_rd = `IO_UNMAPPED_RD;  // slot 3 has no device behind it.
        end else begin
            m_rd = mem_rd;           // not an I/O access, so memory answers.
        end
    end

endmodule

/* src/io_bus_if.sv */
interface io_bus_if;
    import mmio_pkg::*;

    logic     en;   // the slot is addressed in this cycle.
    logic     we;   // the access is a write.
    reg_off_t off;  // register index inside the slot.
    word_t    wd;   // write data from the processor.
    word_t    rd;   // read data, combinational from off.

    // the decoder drives the request and takes back the read data.
    modport master (
        output en,
        output we,
        output off,
        output wd,
        input  rd
    );

    // a device takes the request and returns its read data.
    modport slave (
        input  en,
        input  we,
        input  off,
        input  wd,
        output rd
    );

endinterface

/* src/mmio_pkg.sv */
`include "mmio_config.svh"

package mmio_pkg;

    typedef logic [31:0] word_t;  // one bus or register word.

    localparam int SLOT_W = $clog2(`MMIO_SLOT_COUNT);    // bits that pick a slot.
    localparam int OFF_W  = $clog2(`MMIO_SLOT_SIZE) - 2; // bits that pick a word in a slot.
    localparam int ZERO_W = 31 - SLOT_W - OFF_W - 2;     // bits that must be zero for I/O.

    typedef logic [SLOT_W-1:0] slot_t;     // slot index within the I/O window.
    typedef logic [OFF_W-1:0]  reg_off_t;  // register index within one slot.
    typedef logic [15:0]       led_t;      // value shown on the LED bank.

    // the I/O view of a bus address.
    typedef struct packed {
        logic              is_io_high;  // set for every address in the I/O window.
        logic [ZERO_W-1:0] zero_field;  // all zero inside the 256-byte window.
        slot_t             slot;        // selects one of the four devices.
        reg_off_t          offset;      // word offset that the device decodes.
        logic [1:0]        byte_lane;   // ignored, since accesses are whole words.
    } io_addr_t;

    // the decoder reads one address word both as memory and as I/O.
    typedef union packed {
        word_t    mem;  // the address as the memory port sees it.
        io_addr_t io;   // the address split into its I/O fields.
    } bus_addr_u;

endpackage

/* include/mmio_config.svh */
`ifndef MMIO_CONFIG_SVH
`define MMIO_CONFIG_SVH

// I/O window and slot layout.
`define MMIO_IO_BASE    32'h8000_0000  // first byte of the I/O window.
`define MMIO_SLOT_SIZE  64             // bytes per slot, sixteen 32-bit registers.
`define MMIO_SLOT_COUNT 4              // slots 0 to 2 hold devices and slot 3 is empty.

// SPI timing.
`define SPI_CLK_DIV     4              // system clocks per sclk half period.

// GPIO block.
`define GPIO_WIDTH      8              // number of input pins and of output pins.

// read value for empty slots and for offsets that map to no register.
`define IO_UNMAPPED_RD  32'hFFFF_FFFF

`endif
